/* testbench/aesInvCipher_patterns.hex */
// columns: key, ciphertext, expected plaintext, gap flag (1 = random idle cycles before the block)
// a key that differs from the previous line drains the pipeline and reloads the schedule
000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff 0
2b7e151628aed2a6abf7158809cf4f3c 3925841d02dc09fbdc118597196a0b32 3243f6a8885a308d313198a2e0370734 0
2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97 6bc1bee22e409f96e93d7e117393172a 0
2b7e151628aed2a6abf7158809cf4f3c f5d3d58503b9699de785895a96fdbaaf ae2d8a571e03ac9c9eb76fac45af8e51 0
2b7e151628aed2a6abf7158809cf4f3c 43b1cd7f598ece23881b00e3ed030688 30c81c46a35ce411e5fbc1191a0a52ef 0
2b7e151628aed2a6abf7158809cf4f3c 7b0c785e27e8ad3f8223207104725dd4 f69f2445df4f9b17ad2b417be66c3710 0
2b7e151628aed2a6abf7158809cf4f3c 7b0c785e27e8ad3f8223207104725dd4 f69f2445df4f9b17ad2b417be66c3710 1
2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97 6bc1bee22e409f96e93d7e117393172a 1
2b7e151628aed2a6abf7158809cf4f3c 3925841d02dc09fbdc118597196a0b32 3243f6a8885a308d313198a2e0370734 1
2b7e151628aed2a6abf7158809cf4f3c 43b1cd7f598ece23881b00e3ed030688 30c81c46a35ce411e5fbc1191a0a52ef 1
2b7e151628aed2a6abf7158809cf4f3c f5d3d58503b9699de785895a96fdbaaf ae2d8a571e03ac9c9eb76fac45af8e51 1
00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e 00000000000000000000000000000000 0
00000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34 80000000000000000000000000000000 0
00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e 00000000000000000000000000000000 1
000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff 0
000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff 1

/* src.f */
+incdir+src
src/aesPkg.sv
src/keyExpansion.sv
src/invSubBytes.sv
src/invMixColumns.sv
src/invRoundStage.sv
src/aesInvCipher.sv
testbench/aesInvCipher_assertions.sv
testbench/aesInvCipherTb.sv

/* run.sh */
#!/bin/sh
# builds the AES decryption testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module aesInvCipherTb -f src.f -o aesInvCipherSim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/aesInvCipherSim; then
    echo "simulation reported a failure"
    exit 1
fi

exit 0

/* testbench/aesInvCipherTb.sv */
`timescale 1ns/1ps
`include "aes_params.svh"

module aesInvCipherTb;

    localparam int numVectors = 16;
    localparam int drainLimit = 4 * `AES_LATENCY;

    logic          clk = 1'b0;
    logic          rst_n;
    aesPkg::stateT key;
    aesPkg::stateT cipherText;
    logic          validIn;
    aesPkg::stateT plainText;
    logic          validOut;

    // four words per vector: key, ciphertext, plaintext, gap flag.
    logic [127:0]  patterns [0:4*numVectors-1];

    aesPkg::stateT expectedQ [$];
    int            inCycleQ [$]; // cycle in which each block was driven.
    int            cycleCount;
    int            outCount;
    integer        seed;

    aesInvCipher DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .key       (key),
        .cipherText(cipherText),
        .validIn   (validIn),
        .plainText (plainText),
        .validOut  (validOut)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic checkValue(input logic [127:0] actual, input logic [127:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Gave up waiting for %s at %0t ns.", what, $time);
        $display("Test FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic driveBlock(input aesPkg::stateT ct, input aesPkg::stateT pt);
        @(posedge clk);
        #1;
        cipherText = ct;
        validIn = 1'b1;
        expectedQ.push_back(pt);
        inCycleQ.push_back(cycleCount);
    endtask

    task automatic driveIdle();
        @(posedge clk);
        #1;
        validIn = 1'b0;
    endtask

    task automatic insertGap();
        int idleCycles;
        idleCycles = 1 + int'($unsigned($random(seed)) % 4);
        repeat (idleCycles) begin
            driveIdle();
        end
    endtask

    // new key only with an empty pipeline, then one cycle for the schedule.
    task automatic loadKey(input aesPkg::stateT newKey);
        @(posedge clk);
        #1;
        validIn = 1'b0;
        key = newKey;
        @(posedge clk);
    endtask

    task automatic drainPipeline();
        int waited;
        waited = 0;
        while (expectedQ.size() != 0) begin
            if (waited >= drainLimit) begin
                reportTimeout("the pipeline to drain");
            end else begin
                @(posedge clk);
                waited++;
            end
        end
    endtask

    // outputs are sampled mid-cycle.
    always @(negedge clk) begin : monitor
        aesPkg::stateT expected;
        int inCycle;
        if (!rst_n) begin
            checkValue(128'(validOut), 128'd0, "validOut during reset");
        end else if (validOut === 1'b1) begin
            if (expectedQ.size() == 0) begin
                $display("validOut went high at %0t ns with no block in flight.", $time);
                $display("Test FAILED");
                $fatal(1, "spurious output");
            end else begin
                expected = expectedQ.pop_front();
                inCycle = inCycleQ.pop_front();
                checkValue(128'(cycleCount - inCycle), 128'(`AES_LATENCY),
                           $sformatf("latency of block %0d", outCount));
                checkValue(plainText, expected, $sformatf("plaintext of block %0d", outCount));
                outCount++;
            end
        end
    end

    initial begin : stimulus
        logic [127:0] vKey;
        logic [127:0] vCt;
        logic [127:0] vPt;
        logic [127:0] vGap;
        logic         keyLoaded;
        seed = 32'hf13b;
        rst_n = 1'b0;
        key = '0;
        cipherText = '0;
        validIn = 1'b0;
        cycleCount = 0;
        outCount = 0;
        keyLoaded = 1'b0;
        $readmemh("testbench/aesInvCipher_patterns.hex", patterns);

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle pipeline must stay quiet.
        repeat (2 * `AES_LATENCY) begin
            driveIdle();
        end

        for (int v = 0; v < numVectors; v++) begin
            vKey = patterns[4*v];
            vCt = patterns[4*v+1];
            vPt = patterns[4*v+2];
            vGap = patterns[4*v+3];
            if (!keyLoaded || vKey !== key) begin
                driveIdle();
                drainPipeline();
                loadKey(vKey);
                keyLoaded = 1'b1;
            end else if (vGap != 0) begin
                insertGap();
            end
            driveBlock(vCt, vPt);
        end

        driveIdle();
        drainPipeline();
        repeat (2 * `AES_LATENCY) begin
            driveIdle();
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* testbench/aesInvCipher_assertions.sv */
`timescale 1ns/1ps
`include "aes_params.svh"

module aesInvCipherAssertions (
    input logic          clk,
    input logic          rst_n,
    input logic          validIn,
    input logic          validOut,
    input aesPkg::stateT plainText
);

    // edges since reset, saturating once the pipeline holds only real history.
    int cyclesAfterReset;

    always @(posedge clk) begin
        if (!rst_n) begin
            cyclesAfterReset <= 0;
        end else if (cyclesAfterReset < `AES_LATENCY) begin
            cyclesAfterReset <= cyclesAfterReset + 1;
        end
    end

    quietAfterReset: assert property (@(posedge clk) !rst_n |=> !validOut)
        else $error("validOut high in the cycle after reset");

    validDelay: assert property (@(posedge clk) disable iff (!rst_n)
        (cyclesAfterReset == `AES_LATENCY) |-> (validOut == $past(validIn, `AES_LATENCY)))
        else $error("validOut is not validIn delayed by the pipeline latency");

    knownData: assert property (@(posedge clk) disable iff (!rst_n)
        validOut |-> !$isunknown(plainText))
        else $error("plainText has unknown bits while valid");

endmodule

bind aesInvCipher aesInvCipherAssertions assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .validIn  (validIn),
    .validOut (validOut),
    .plainText(plainText)
);

/* src/aesInvCipher.sv */
`timescale 1ns/1ps
`include "aes_params.svh"

module aesInvCipher (
    input  logic          clk,
    input  logic          rst_n,
    input  aesPkg::stateT key,
    input  aesPkg::stateT cipherText,
    input  logic          validIn,
    output aesPkg::stateT plainText,
    output logic          validOut
);

    aesPkg::roundKeysT roundKeys;

    // pipeState[i] holds the block after round key i was applied.
    aesPkg::stateT pipeState [`AES_LATENCY-1:0];
    logic          pipeValid [`AES_LATENCY-1:0];

    keyExpansion keySchedule (
        .clk      (clk),
        .rst_n    (rst_n),
        .key      (key),
        .roundKeys(roundKeys)
    );

    // initial add-round-key with the last round key.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pipeState[`AES_NR] <= '0;
            pipeValid[`AES_NR] <= 1'b0;
        end else begin
            pipeState[`AES_NR] <= cipherText ^ roundKeys[`AES_NR];
            pipeValid[`AES_NR] <= validIn;
        end
    end

    generate
        for (genvar gi = `AES_NR - 1; gi >= 0; gi--) begin : gRound
            invRoundStage #(
                .finalRound(gi == 0)
            ) stage (
                .clk     (clk),
                .rst_n   (rst_n),
                .stateIn (pipeState[gi+1]),
                .validIn (pipeValid[gi+1]),
                .roundKey(roundKeys[gi]),
                .stateOut(pipeState[gi]),
                .validOut(pipeValid[gi])
            );
        end
    endgenerate

    assign plainText = pipeState[0];
    assign validOut  = pipeValid[0];

endmodule

/* src/invRoundStage.sv */
`timescale 1ns/1ps

module invRoundStage #(
    parameter bit finalRound = 1'b0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  aesPkg::stateT stateIn,
    input  logic          validIn,
    input  aesPkg::stateT roundKey,
    output aesPkg::stateT stateOut,
    output logic          validOut
);

    aesPkg::stateT shifted;
    aesPkg::stateT substituted;
    aesPkg::stateT keyed;
    aesPkg::stateT roundResult;

    // row r rotates right by r columns.
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted[127-8*(4*c+r) -: 8] = stateIn[127-8*(4*((c+4-r)%4)+r) -: 8];
            end
        end
    end

    invSubBytes subBytes (
        .stateIn (shifted),
        .stateOut(substituted)
    );

    assign keyed = substituted ^ roundKey;

    generate
        if (finalRound) begin : gLast
            assign roundResult = keyed; // no mix-columns in the last round.
        end else begin : gMix
            invMixColumns mixColumns (
                .stateIn (keyed),
                .stateOut(roundResult)
            );
        end
    endgenerate

    // data moves every cycle, valid just tags it.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stateOut <= '0;
            validOut <= 1'b0;
        end else begin
            stateOut <= roundResult;
            validOut <= validIn;
        end
    end

endmodule

/* src/invMixColumns.sv */
`timescale 1ns/1ps

module invMixColumns (
    input  aesPkg::stateT stateIn,
    output aesPkg::stateT stateOut
);

    aesPkg::byteT m9 [0:15];
    aesPkg::byteT mb [0:15];
    aesPkg::byteT md [0:15];
    aesPkg::byteT me [0:15];

    // per-byte products, index is 4*column + row.
    always_comb begin : products
        aesPkg::byteT b;
        aesPkg::byteT x2;
        aesPkg::byteT x4;
        aesPkg::byteT x8;
        for (int i = 0; i < 16; i++) begin
            b = stateIn[127-8*i -: 8];
            x2 = aesPkg::xtime(b);
            x4 = aesPkg::xtime(x2);
            x8 = aesPkg::xtime(x4);
            m9[i] = x8 ^ b;
            mb[i] = x8 ^ x2 ^ b;
            md[i] = x8 ^ x4 ^ b;
            me[i] = x8 ^ x4 ^ x2;
        end
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            stateOut[127-32*c -: 8]  = me[4*c] ^ mb[4*c+1] ^ md[4*c+2] ^ m9[4*c+3];
            stateOut[119-32*c -: 8]  = m9[4*c] ^ me[4*c+1] ^ mb[4*c+2] ^ md[4*c+3];
            stateOut[111-32*c -: 8]  = md[4*c] ^ m9[4*c+1] ^ me[4*c+2] ^ mb[4*c+3];
            stateOut[103-32*c -: 8]  = mb[4*c] ^ md[4*c+1] ^ m9[4*c+2] ^ me[4*c+3];
        end
    end

endmodule

/* src/invSubBytes.sv */
`timescale 1ns/1ps

module invSubBytes (
    input  aesPkg::stateT stateIn,
    output aesPkg::stateT stateOut
);

    // inverse affine map, undoes the 63 constant too.
    function automatic aesPkg::byteT invAffine(aesPkg::byteT b);
        return {b[6:0], b[7]} ^ {b[4:0], b[7:5]} ^ {b[1:0], b[7:2]} ^ 8'h05;
    endfunction

    function automatic aesPkg::byteT invSbox(aesPkg::byteT b);
        return aesPkg::gfInverse(invAffine(b));
    endfunction

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            stateOut[8*i +: 8] = invSbox(stateIn[8*i +: 8]);
        end
    end

endmodule

/* src/keyExpansion.sv */
`timescale 1ns/1ps
`include "aes_params.svh"

module keyExpansion (
    input  logic              clk,
    input  logic              rst_n,
    input  aesPkg::stateT     key,
    output aesPkg::roundKeysT roundKeys
);

    localparam int numWords = 4 * (`AES_NR + 1);

    aesPkg::wordT      w [0:numWords-1];
    aesPkg::roundKeysT roundKeysNext;

    // forward s-box, field inverse then affine map.
    function automatic aesPkg::byteT sbox(aesPkg::byteT b);
        aesPkg::byteT inv;
        inv = aesPkg::gfInverse(b);
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    function automatic aesPkg::wordT subRotWord(aesPkg::wordT word);
        aesPkg::wordT result;
        result[0] = sbox(word[1]); // rotate left by one byte.
        result[1] = sbox(word[2]);
        result[2] = sbox(word[3]);
        result[3] = sbox(word[0]);
        return result;
    endfunction

    always_comb begin : expand
        aesPkg::wordT temp;
        aesPkg::byteT rcon;
        rcon = 8'h01;
        for (int i = 0; i < `AES_NK; i++) begin
            w[i] = key[`AES_STATE_BITS-1-32*i -: 32];
        end
        for (int i = `AES_NK; i < numWords; i++) begin
            temp = w[i-1];
            if (i % `AES_NK == 0) begin
                temp = subRotWord(temp);
                temp[0] = temp[0] ^ rcon;
                rcon = aesPkg::xtime(rcon); // 01, 02, 04 ... 1b, 36.
            end
            w[i] = w[i-`AES_NK] ^ temp;
        end
        for (int r = 0; r <= `AES_NR; r++) begin
            roundKeysNext[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            roundKeys <= '0;
        end else begin
            roundKeys <= roundKeysNext;
        end
    end

endmodule

/* src/aesPkg.sv */
`include "aes_params.svh"

package aesPkg;

    typedef logic [7:0] byteT;

    // byte 0 is the most significant.
    typedef byteT [0:3] wordT;

    // column-major, byte 0 in the top bits.
    typedef logic [`AES_STATE_BITS-1:0] stateT;

    // round key r lives at index r.
    typedef stateT [`AES_NR:0] roundKeysT;

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1.
    function automatic byteT xtime(byteT b);
        byteT shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7]) begin
            shifted = shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

    function automatic byteT gfMul(byteT a, byteT b);
        byteT acc;
        byteT addend;
        acc = 8'h00;
        addend = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ addend;
            end
            addend = xtime(addend); // next power of x.
        end
        return acc;
    endfunction

    // a^254 by repeated squaring, so zero stays zero.
    function automatic byteT gfInverse(byteT a);
        byteT result;
        byteT square;
        result = 8'h01;
        square = a;
        for (int i = 1; i < 8; i++) begin
            square = gfMul(square, square); // a^(2^i).
            result = gfMul(result, square);
        end
        return result;
    endfunction

endpackage

/* src/aes_params.svh */
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// key length in 32-bit words.
`define AES_NK 4

// number of cipher rounds for a 128-bit key.
`define AES_NR 10

// block width.
`define AES_STATE_BITS 128

// initial add-round-key register plus one register per round.
`define AES_LATENCY (`AES_NR + 1)

`endif
